// ==== include/mem_subsys_defines.svh ====
`ifndef MEM_SUBSYS_DEFINES_SVH
`define MEM_SUBSYS_DEFINES_SVH

// Extra cycles the RAM waits before each ack
// Valid range is 0 to 7, the counter is three bits wide
`define MEM_WAIT_STATES 2

// Prefetch FIFO entries, must be a power of two
`define PFQ_DEPTH 4

// Implemented word address bits of the RAM
// Upper word address bits alias onto these
`define RAM_WORDS_LOG2 10

`endif

// ==== src/mem_bus_pkg.sv ====
package mem_bus_pkg;

    // Request from one bus master
    // addr is the word address, byte address bits 19 to 1
    typedef struct packed {
        logic [18:0] addr;
        logic [15:0] wdata;
        logic        wr_en;
        // Bit 0 selects the low byte, bit 1 the high byte
        logic [1:0]  bytesel;
        // Level, held until ack is seen
        logic        access;
    } bus_req_t;

    // Response back to one master
    // rdata only carries data in the ack cycle
    typedef struct packed {
        logic [15:0] rdata;
        logic        ack;
    } bus_rsp_t;

    // One bus word, seen whole or as two byte lanes
    typedef union packed {
        logic [15:0] word;
        struct packed {
            logic [7:0] hi_byte;
            logic [7:0] lo_byte;
        } bytes;
    } bus_word_u;

endpackage

// ==== src/id_arbiter.sv ====
`timescale 1ns/1ns

module id_arbiter
    import mem_bus_pkg::*;
(
    input  logic     clk,
    input  logic     reset,

    // Instruction master, the prefetch queue
    input  bus_req_t instr_req,
    output bus_rsp_t instr_rsp,

    // Data master, the load/store path
    input  bus_req_t data_req,
    output bus_rsp_t data_rsp,

    // Shared memory bus
    output bus_req_t mem_req,
    input  bus_rsp_t mem_rsp,

    output logic     busy
);

    // Idle samples the access lines, serving holds the grant until ack
    typedef enum logic {
        ARB_IDLE,
        ARB_SERVING
    } arb_state_t;

    arb_state_t arb_state;

    // Set when the instruction master got the last completed access
    logic last_served_instr;
    // Winner of the current grant
    logic serving_instr;

    logic grant;
    logic pick_instr;
    logic any_access;
    logic instr_ack;
    logic data_ack;
    bus_req_t winner_req;

    // Round-robin pick
    // The instruction side wins unless data is also pending and
    // instruction was the last one served
    always_comb begin
        any_access = instr_req.access | data_req.access;
        pick_instr = instr_req.access & (~data_req.access | ~last_served_instr);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            arb_state         <= ARB_IDLE;
            last_served_instr <= 1'b0;
            serving_instr     <= 1'b0;
        end else begin
            case (arb_state)
                ARB_IDLE: begin
                    // Grant one cycle after access is seen
                    if (any_access) begin
                        arb_state     <= ARB_SERVING;
                        serving_instr <= pick_instr;
                    end
                end

                ARB_SERVING: begin
                    // Release on the ack edge, winner becomes last served
                    if (mem_rsp.ack) begin
                        arb_state         <= ARB_IDLE;
                        last_served_instr <= serving_instr;
                    end
                end

                default: begin
                    arb_state <= ARB_IDLE;
                end
            endcase
        end
    end

    // The serving state is the registered memory access
    assign grant = (arb_state == ARB_SERVING);
    assign busy  = grant;

    // Steer the recorded winner onto the memory bus
    always_comb begin
        winner_req     = serving_instr ? instr_req : data_req;
        mem_req        = winner_req;
        mem_req.access = grant;
    end

    // Ack goes to the winner only, and only while the grant is held
    assign instr_ack = grant & serving_instr & mem_rsp.ack;
    assign data_ack  = grant & ~serving_instr & mem_rsp.ack;

    always_comb begin
        instr_rsp.ack = instr_ack;
        data_rsp.ack  = data_ack;
        // Read data reads as zero to the master not being served
        instr_rsp.rdata = instr_ack ? mem_rsp.rdata : 16'h0000;
        data_rsp.rdata  = data_ack ? mem_rsp.rdata : 16'h0000;
    end

endmodule

// ==== src/prefetch_queue.sv ====
`timescale 1ns/1ns
`include "mem_subsys_defines.svh"

module prefetch_queue
    import mem_bus_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    // Restart fetching at a new word address
    input  logic        flush,
    input  logic [18:0] flush_addr,

    // Consumer side, head word shown combinationally
    input  logic        pop,
    output logic [15:0] word,
    output logic        word_valid,

    // Memory side, towards the arbiter
    output bus_req_t    fetch_req,
    input  bus_rsp_t    fetch_rsp
);

    localparam int DEPTH = `PFQ_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(DEPTH);

    logic [15:0] fifo_mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0] count;
    logic [PTR_W:0] count_nxt;

    // Next word address to request
    logic [18:0] fetch_addr;
    logic [18:0] fetch_addr_nxt;
    // Address of the read on the bus, held until ack
    logic [18:0] req_addr;

    logic outstanding;
    // Outstanding read was issued before the last flush
    logic discard;

    logic ack;
    logic push;
    logic pop_ok;
    logic issue;

    assign ack    = fetch_rsp.ack;
    // A word arriving with a flush is stale as well
    assign push   = ack & ~discard & ~flush;
    assign pop_ok = pop & (count != '0) & ~flush;

    always_comb begin
        fetch_addr_nxt = fetch_addr;
        count_nxt      = count;
        if (flush) begin
            fetch_addr_nxt = flush_addr;
            count_nxt      = '0;
        end else begin
            if (ack && !discard) begin
                fetch_addr_nxt = fetch_addr + 19'd1;
            end
            if (push && !pop_ok) begin
                count_nxt = count + 1'b1;
            end else if (!push && pop_ok) begin
                count_nxt = count - 1'b1;
            end
        end
    end

    // New read when the bus is free of our request and one slot remains
    assign issue = (~outstanding | ack) & (count_nxt < FULL_COUNT);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            fetch_addr  <= '0;
            req_addr    <= '0;
            outstanding <= 1'b0;
            discard     <= 1'b0;
        end else begin
            count      <= count_nxt;
            fetch_addr <= fetch_addr_nxt;
            if (flush) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
            end else begin
                if (push) begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
                if (pop_ok) begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            // Access stays high until ack, then maybe straight into the next read
            if (!outstanding || ack) begin
                outstanding <= issue;
            end
            if (issue) begin
                req_addr <= fetch_addr_nxt;
            end
            // A read still in flight across a flush gets dropped
            discard <= flush ? (outstanding & ~ack) : (discard & ~ack);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= fetch_rsp.rdata;
        end
    end

    assign word       = fifo_mem[rd_ptr];
    assign word_valid = (count != '0);

    // Whole-word reads only
    always_comb begin
        fetch_req.addr    = req_addr;
        fetch_req.wdata   = 16'h0000;
        fetch_req.wr_en   = 1'b0;
        fetch_req.bytesel = 2'b11;
        fetch_req.access  = outstanding;
    end

endmodule

// ==== src/word_ram.sv ====
`timescale 1ns/1ns
`include "mem_subsys_defines.svh"

module word_ram
    import mem_bus_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  bus_req_t req,
    output bus_rsp_t rsp
);

    localparam int RAM_WORDS = 1 << `RAM_WORDS_LOG2;
    localparam logic [2:0] WAIT_LAST = 3'(`MEM_WAIT_STATES);

    // Storage starts out all zero
    logic [15:0] mem [RAM_WORDS] = '{default: 16'h0000};

    // Cycles of the current access so far
    logic [2:0] wait_cnt;
    logic ack;
    logic [`RAM_WORDS_LOG2-1:0] idx;

    bus_word_u cur_word;
    bus_word_u wr_word;
    bus_word_u merged_word;

    // High word address bits are ignored, so the RAM aliases
    assign idx = req.addr[`RAM_WORDS_LOG2-1:0];

    // Ack after the wait states, in the same cycle when there are none
    assign ack = req.access & (wait_cnt == WAIT_LAST);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wait_cnt <= '0;
        end else if (!req.access || ack) begin
            // Access drops after an ack, so count from zero again
            wait_cnt <= '0;
        end else begin
            wait_cnt <= wait_cnt + 3'd1;
        end
    end

    // Byte lane merge of write data onto the stored word
    always_comb begin
        cur_word.word = mem[idx];
        wr_word.word  = req.wdata;
        merged_word   = cur_word;
        if (req.bytesel[0]) begin
            merged_word.bytes.lo_byte = wr_word.bytes.lo_byte;
        end
        if (req.bytesel[1]) begin
            merged_word.bytes.hi_byte = wr_word.bytes.hi_byte;
        end
    end

    // Write lands on the ack edge
    always_ff @(posedge clk) begin
        if (ack && req.wr_en) begin
            mem[idx] <= merged_word.word;
        end
    end

    always_comb begin
        rsp.ack = ack;
        // Zero outside the ack cycle
        rsp.rdata = ack ? cur_word.word : 16'h0000;
    end

endmodule

// ==== src/mem_subsys_top.sv ====
`timescale 1ns/1ns

module mem_subsys_top
    import mem_bus_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    // Data master port, driven by the execution side
    input  bus_req_t    data_req,
    output bus_rsp_t    data_rsp,

    // Instruction fetch port
    input  logic        flush,
    input  logic [18:0] flush_addr,
    input  logic        pop,
    output logic [15:0] word,
    output logic        word_valid,

    // Shared bus held by either master
    output logic        busy
);

    bus_req_t instr_req;
    bus_rsp_t instr_rsp;
    bus_req_t mem_req;
    bus_rsp_t mem_rsp;

    // Sequential instruction reads into the prefetch FIFO
    prefetch_queue u_prefetch_queue (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .flush_addr (flush_addr),
        .pop        (pop),
        .word       (word),
        .word_valid (word_valid),
        .fetch_req  (instr_req),
        .fetch_rsp  (instr_rsp)
    );

    // Round-robin between fetch and data
    id_arbiter u_id_arbiter (
        .clk       (clk),
        .reset     (reset),
        .instr_req (instr_req),
        .instr_rsp (instr_rsp),
        .data_req  (data_req),
        .data_rsp  (data_rsp),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp),
        .busy      (busy)
    );

    word_ram u_word_ram (
        .clk   (clk),
        .reset (reset),
        .req   (mem_req),
        .rsp   (mem_rsp)
    );

endmodule

// ==== tests/tb_mem_subsys.sv ====
`timescale 1ns/1ns
`include "mem_subsys_defines.svh"

module tb_mem_subsys
    import mem_bus_pkg::*;
();

    localparam int WS = `MEM_WAIT_STATES;
    localparam int TRANS_LEN = 2 + WS;
    // Worst data wait, one full fetch ahead of it plus the idle cycle
    localparam int FAIR_LIMIT = 2 * TRANS_LEN + 1;
    localparam int RAM_WORDS = 1 << `RAM_WORDS_LOG2;
    // Data reads and writes plus fetches for the popped words, rounded up
    localparam int N_TRANS = 256;
    localparam int TIMEOUT_CYCLES = N_TRANS * 2 * TRANS_LEN + 1000;

    logic        clk;
    logic        reset;
    bus_req_t    data_req;
    bus_rsp_t    data_rsp;
    logic        flush;
    logic [18:0] flush_addr;
    logic        pop = 1'b0;
    logic [15:0] word;
    logic        word_valid;
    logic        busy;

    // Reference copy of the RAM contents
    logic [15:0] model [RAM_WORDS] = '{default: 16'h0000};

    logic [15:0] exp_rdata = 16'h0000;
    logic        rd_active = 1'b0;
    // Word address the head of the prefetch FIFO must hold
    logic [18:0] exp_addr = '0;
    logic        pop_en;
    logic        first_after = 1'b0;
    int          data_wait = 0;
    int          pops = 0;
    int          errors = 0;
    int          checks = 0;
    int          cycles;

    mem_subsys_top uut (
        .clk        (clk),
        .reset      (reset),
        .data_req   (data_req),
        .data_rsp   (data_rsp),
        .flush      (flush),
        .flush_addr (flush_addr),
        .pop        (pop),
        .word       (word),
        .word_valid (word_valid),
        .busy       (busy)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Bookkeeping on the edge, using the values of the cycle that ends
    always @(posedge clk) begin
        first_after <= reset;
        if (reset || first_after)
            checks++;
        if (data_rsp.ack)
            checks++;
        if (flush) begin
            exp_addr <= flush_addr;
        end else if (pop && word_valid) begin
            exp_addr <= exp_addr + 19'd1;
            pops <= pops + 1;
            checks++;
        end
        // Cycles the current data access has waited so far
        if (data_req.access && !data_rsp.ack)
            data_wait <= data_wait + 1;
        else
            data_wait <= 0;
    end

    // Random consumer of the fetched words
    always @(posedge clk) begin
        pop <= pop_en & 1'($urandom_range(0, 1));
    end

    // Checks sampled mid-cycle, where every output has settled
    assert property (@(negedge clk)
        !(reset || first_after) || (!data_rsp.ack && !busy && !word_valid))
    else begin
        errors++;
        $display("Fail %0t data_rsp.ack,busy,word_valid expected 000 got %b%b%b",
            $time, data_rsp.ack, busy, word_valid);
    end

    assert property (@(negedge clk)
        !(data_rsp.ack && rd_active) || data_rsp.rdata == exp_rdata)
    else begin
        errors++;
        $display("Fail %0t data_rsp.rdata expected %h got %h",
            $time, exp_rdata, data_rsp.rdata);
    end

    assert property (@(negedge clk) data_rsp.ack || data_rsp.rdata == 16'h0000)
    else begin
        errors++;
        $display("Fail %0t data_rsp.rdata expected 0000 got %h", $time, data_rsp.rdata);
    end

    assert property (@(negedge clk)
        !(pop && word_valid && !flush)
        || word == model[exp_addr[`RAM_WORDS_LOG2-1:0]])
    else begin
        errors++;
        $display("Fail %0t word expected %h got %h",
            $time, model[exp_addr[`RAM_WORDS_LOG2-1:0]], word);
    end

    assert property (@(negedge clk) !data_req.access || data_wait <= FAIR_LIMIT)
    else begin
        errors++;
        $display("Fail %0t data_rsp.ack wait expected <= %0d got %0d",
            $time, FAIR_LIMIT, data_wait);
    end

    // Word address in the low window, upper bits random to hit the aliases
    function automatic logic [18:0] aliased_addr(input int offset);
        return (19'($urandom) << `RAM_WORDS_LOG2) | 19'(offset);
    endfunction

    // One data master access, held until ack, dropped on the ack edge
    task automatic bus_access(input bus_req_t req, output logic [15:0] rdata);
        @(posedge clk);
        data_req <= req;
        @(negedge clk);
        while (!data_rsp.ack)
            @(negedge clk);
        rdata = data_rsp.rdata;
        @(posedge clk);
        data_req.access <= 1'b0;
    endtask

    task automatic write_bytes(input logic [18:0] addr, input logic [15:0] data,
                               input logic [1:0] sel);
        bus_req_t req;
        bus_word_u cur;
        bus_word_u wv;
        logic [15:0] unused;
        req = '0;
        req.addr = addr;
        req.wdata = data;
        req.wr_en = 1'b1;
        req.bytesel = sel;
        req.access = 1'b1;
        bus_access(req, unused);
        // Merge the enabled lanes into the model word
        cur.word = model[addr[`RAM_WORDS_LOG2-1:0]];
        wv.word = data;
        if (sel[0])
            cur.bytes.lo_byte = wv.bytes.lo_byte;
        if (sel[1])
            cur.bytes.hi_byte = wv.bytes.hi_byte;
        model[addr[`RAM_WORDS_LOG2-1:0]] = cur.word;
    endtask

    task automatic write_word(input logic [18:0] addr, input logic [15:0] data);
        write_bytes(addr, data, 2'b11);
    endtask

    task automatic read_word(input logic [18:0] addr, output logic [15:0] data);
        bus_req_t req;
        req = '0;
        req.addr = addr;
        req.bytesel = 2'b11;
        req.access = 1'b1;
        exp_rdata = model[addr[`RAM_WORDS_LOG2-1:0]];
        rd_active = 1'b1;
        bus_access(req, data);
        rd_active = 1'b0;
    endtask

    task automatic flush_to(input logic [18:0] addr);
        @(posedge clk);
        flush <= 1'b1;
        flush_addr <= addr;
        @(posedge clk);
        flush <= 1'b0;
    endtask

    task automatic wait_pops(input int n);
        int target;
        target = pops + n;
        while (pops < target)
            @(posedge clk);
    endtask

    // Run limit
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the test sequence did not finish", cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        logic [15:0] rd;
        logic [18:0] a;
        void'($urandom(32'hbb60));
        reset <= 1'b1;
        data_req <= '0;
        flush <= 1'b0;
        flush_addr <= '0;
        pop_en <= 1'b0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        repeat (2) @(posedge clk);

        // Fill the low window with random words, then read back at random
        for (int i = 0; i < 64; i++)
            write_word(aliased_addr(i), 16'($urandom));
        for (int i = 0; i < 24; i++)
            read_word(aliased_addr($urandom_range(0, 63)), rd);

        // Single byte lane writes
        for (int i = 0; i < 16; i++) begin
            a = aliased_addr($urandom_range(0, 63));
            write_bytes(a, 16'($urandom), $urandom_range(0, 1) ? 2'b01 : 2'b10);
            read_word(a, rd);
        end

        // Sequential fetch with data reads competing for the bus
        flush_to(aliased_addr($urandom_range(0, 47)));
        @(posedge clk);
        pop_en <= 1'b1;
        for (int i = 0; i < 20; i++)
            read_word(aliased_addr($urandom_range(0, 63)), rd);
        wait_pops(40);

        // Flush again while the fetch to the previous address is on the bus
        for (int i = 0; i < 4; i++) begin
            flush_to(aliased_addr($urandom_range(0, 47)));
            @(negedge clk);
            while (!busy)
                @(negedge clk);
            flush_to(aliased_addr($urandom_range(0, 47)));
            wait_pops(8);
        end

        @(posedge clk);
        pop_en <= 1'b0;
        repeat (4) @(posedge clk);
        $display("Summary: %0d errors, %0d checks", errors, checks);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== mem_subsys.f ====
+incdir+include
src/mem_bus_pkg.sv
src/id_arbiter.sv
src/prefetch_queue.sv
src/word_ram.sv
src/mem_subsys_top.sv
tests/tb_mem_subsys.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f mem_subsys.f --top-module tb_mem_subsys

output=$(./obj_dir/Vtb_mem_subsys)
echo "$output"

if echo "$output" | grep -q "TESTBENCH PASSED"; then
    exit 0
fi
exit 1
